/* list.f */
app_stream_pkg.sv
app_reg_pkg.sv
app_reg_file.sv
h2c_checker.sv
c2h_generator.sv
sgdma_app.sv
tb_sgdma_app.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator from list.f, run, and search the log for the fail message

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_sgdma_app -f list.f -o tb_sgdma_app
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sgdma_app > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

/* tb_sgdma_app.sv */
// DMA user test application testbench that applies a table of stream rows and checks the results
`timescale 1ns/1ns
`default_nettype none

module tb_sgdma_app import app_stream_pkg::*, app_reg_pkg::*; ();

	localparam int DW = DATA_W_DEF;
	localparam int NROWS = 11;
	localparam logic [15:0] NO_BAD = 16'hFFFF;

	// one table row of mode, frame length and corrupted beat index
	typedef struct packed {
		app_mode_e   mode;
		logic [15:0] len;
		logic [15:0] bad;
	} row_t;

	localparam row_t ROWS [NROWS] = '{
		'{MODE_C2H, 16'd1, NO_BAD},
		'{MODE_C2H, 16'd6, NO_BAD},
		'{MODE_H2C, 16'd4, NO_BAD},
		'{MODE_H2C, 16'd7, 16'd2},
		'{MODE_H2C, 16'd1, 16'd0},
		'{MODE_LOOP, 16'd5, NO_BAD},
		'{MODE_C2H, 16'd0, NO_BAD},
		'{MODE_OFF, 16'd3, NO_BAD},
		'{MODE_C2H, 16'd12, NO_BAD},
		'{MODE_H2C, 16'd9, 16'd8},
		'{MODE_LOOP, 16'd8, NO_BAD}
	};

	logic          usr_clk;
	logic          rst_i;
	logic [31:0]   awaddr;
	logic          awvalid;
	logic          awready;
	logic [31:0]   wdata;
	logic [3:0]    wstrb;
	logic          wvalid;
	logic          wready;
	logic          bvalid;
	logic [1:0]    bresp;
	logic          bready;
	logic [31:0]   araddr;
	logic          arvalid;
	logic          arready;
	logic [31:0]   rdata;
	logic [1:0]    rresp;
	logic          rvalid;
	logic          rready;
	logic [DW-1:0] h2c_tdata;
	logic          h2c_tlast;
	logic          h2c_tvalid;
	logic          h2c_tready;
	logic [DW-1:0] c2h_tdata;
	logic          c2h_tlast;
	logic          c2h_tvalid;
	logic          c2h_tready;
	logic [1:0]    irq_req;
	logic [1:0]    irq_ack;

	logic [15:0]   lfsr;
	logic [31:0]   exp_beats;
	logic [31:0]   exp_errs;

	sgdma_app i_sgdma_app (
		.usr_clk(usr_clk),
		.rst_i(rst_i),
		.awaddr_i(awaddr),
		.awvalid_i(awvalid),
		.awready_o(awready),
		.wdata_i(wdata),
		.wstrb_i(wstrb),
		.wvalid_i(wvalid),
		.wready_o(wready),
		.bvalid_o(bvalid),
		.bresp_o(bresp),
		.bready_i(bready),
		.araddr_i(araddr),
		.arvalid_i(arvalid),
		.arready_o(arready),
		.rdata_o(rdata),
		.rresp_o(rresp),
		.rvalid_o(rvalid),
		.rready_i(rready),
		.h2c_tdata_i(h2c_tdata),
		.h2c_tlast_i(h2c_tlast),
		.h2c_tvalid_i(h2c_tvalid),
		.h2c_tready_o(h2c_tready),
		.c2h_tdata_o(c2h_tdata),
		.c2h_tlast_o(c2h_tlast),
		.c2h_tvalid_o(c2h_tvalid),
		.c2h_tready_i(c2h_tready),
		.usr_irq_req_o(irq_req),
		.usr_irq_ack_i(irq_ack)
	);

	// 40 ns period
	always #20 usr_clk = ~usr_clk;

	// x^16 + x^14 + x^13 + x^11 + 1 shifting left
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one step per bit taken
	function automatic logic rand_bit();
		lfsr = lfsr_next(lfsr);
		return lfsr[0];
	endfunction

	// beat k carries k in both halves
	function automatic logic [DW-1:0] pattern_word(input int k);
		logic [DW/2-1:0] half;
		half = k[DW/2-1:0];
		return {half, half};
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// address and data offered together and the response expected to be OKAY
	task automatic lite_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge usr_clk);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= 4'hF;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		bready  <= 1'b1;
		do @(negedge usr_clk); while (!awready);
		// wready pulses together with awready
		check_value("wready", wready, 1);
		// handshake on this edge
		@(posedge usr_clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do @(negedge usr_clk); while (!bvalid);
		check_value("bresp", bresp, RESP_OKAY);
		@(posedge usr_clk);
		bready <= 1'b0;
	endtask

	task automatic lite_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge usr_clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= 1'b1;
		do @(negedge usr_clk); while (!arready);
		@(posedge usr_clk);
		arvalid <= 1'b0;
		do @(negedge usr_clk); while (!rvalid);
		data = rdata;
		resp = rresp;
		@(posedge usr_clk);
		rready <= 1'b0;
	endtask

	// entered with the req bit already seen high and waits a random delay before ack
	task automatic ack_irq(input int idx);
		int delay;
		delay = 0;
		for (int j = 0; j < 3; j++) begin
			delay = delay * 2 + int'(rand_bit());
		end
		repeat (delay) begin
			@(posedge usr_clk);
			@(negedge usr_clk);
			check_value("usr_irq_req", irq_req, 2'b01 << idx);
			check_value("h2c_tready", h2c_tready, 0);
		end
		@(posedge usr_clk);
		irq_ack[idx] <= 1'b1;
		// any held h2c offer ends with the ack
		h2c_tvalid   <= 1'b0;
		@(posedge usr_clk);
		irq_ack[idx] <= 1'b0;
		@(negedge usr_clk);
		check_value("usr_irq_req", irq_req, 0);
	endtask

	task automatic gen_frame_row(input row_t row);
		int k;
		lite_write(32'(REG_C2H_LEN), 32'(row.len));
		lite_write(32'(REG_CTRL), 32'(MODE_C2H) | (32'd1 << CTRL_START_BIT));
		k = 0;
		while (k < int'(row.len)) begin
			@(posedge usr_clk);
			c2h_tready <= rand_bit();
			@(negedge usr_clk);
			check_value("usr_irq_req", irq_req, 0);
			// data and tlast must hold while stalled
			if (c2h_tvalid) begin
				check_value("c2h_tdata", c2h_tdata, pattern_word(k));
				check_value("c2h_tlast", c2h_tlast, k == int'(row.len) - 1);
				if (c2h_tready) begin
					k++;
				end
			end
		end
		@(posedge usr_clk);
		c2h_tready <= 1'b0;
		@(negedge usr_clk);
		check_value("c2h_tvalid", c2h_tvalid, 0);
		check_value("usr_irq_req", irq_req, 2'b10);
		ack_irq(1);
	endtask

	task automatic checker_frame_row(input row_t row);
		logic [31:0] data;
		logic [1:0]  resp;
		lite_write(32'(REG_CTRL), 32'(MODE_H2C));
		for (int k = 0; k < int'(row.len); k++) begin
			@(posedge usr_clk);
			// random idle gaps between beats
			while (rand_bit()) begin
				h2c_tvalid <= 1'b0;
				@(posedge usr_clk);
			end
			h2c_tvalid <= 1'b1;
			h2c_tlast  <= (k == int'(row.len) - 1);
			h2c_tdata  <= pattern_word(k);
			if (k == int'(row.bad)) begin
				h2c_tdata <= pattern_word(k) ^ {1'b1, {(DW-1){1'b0}}};
			end
			do @(negedge usr_clk); while (!h2c_tready);
		end
		// keep offering a beat while the irq is pending
		@(posedge usr_clk);
		h2c_tdata <= pattern_word(0);
		h2c_tlast <= 1'b0;
		@(negedge usr_clk);
		check_value("usr_irq_req", irq_req, 2'b01);
		check_value("h2c_tready", h2c_tready, 0);
		ack_irq(0);
		exp_beats = exp_beats + 32'(row.len);
		if (row.bad != NO_BAD) begin
			exp_errs = exp_errs + 1;
		end
		lite_read(32'(REG_H2C_BEATS), data, resp);
		check_value("REG_H2C_BEATS", data, exp_beats);
		lite_read(32'(REG_H2C_ERR), data, resp);
		check_value("REG_H2C_ERR", data, exp_errs);
	endtask

	task automatic loopback_row(input row_t row, input int tag);
		int          sent;
		logic [DW-1:0] word;
		lite_write(32'(REG_CTRL), 32'(MODE_LOOP));
		sent = 0;
		while (sent < int'(row.len)) begin
			word = {16'hA5C3, 16'(tag), 32'(sent)};
			@(posedge usr_clk);
			c2h_tready <= rand_bit();
			h2c_tvalid <= 1'b1;
			h2c_tdata  <= word;
			h2c_tlast  <= (sent == int'(row.len) - 1);
			@(negedge usr_clk);
			check_value("h2c_tready", h2c_tready, c2h_tready);
			check_value("c2h_tvalid", c2h_tvalid, 1);
			check_value("c2h_tdata", c2h_tdata, word);
			check_value("c2h_tlast", c2h_tlast, sent == int'(row.len) - 1);
			check_value("usr_irq_req", irq_req, 0);
			if (c2h_tready) begin
				sent++;
			end
		end
		@(posedge usr_clk);
		h2c_tvalid <= 1'b0;
		h2c_tlast  <= 1'b0;
		c2h_tready <= 1'b0;
		@(negedge usr_clk);
		check_value("c2h_tvalid", c2h_tvalid, 0);
		check_value("usr_irq_req", irq_req, 0);
	endtask

	// start in a wrong mode or with length 0 and then look for a frame in MODE_C2H
	task automatic ignored_start_row(input row_t row);
		lite_write(32'(REG_C2H_LEN), 32'(row.len));
		lite_write(32'(REG_CTRL), 32'(row.mode) | (32'd1 << CTRL_START_BIT));
		lite_write(32'(REG_CTRL), 32'(MODE_C2H));
		repeat (50) begin
			@(posedge usr_clk);
			c2h_tready <= rand_bit();
			@(negedge usr_clk);
			check_value("c2h_tvalid", c2h_tvalid, 0);
			check_value("usr_irq_req", irq_req, 0);
		end
		@(posedge usr_clk);
		c2h_tready <= 1'b0;
	endtask

	// watchdog allows 20 cycles per table beat plus 200 per row and one spare share
	initial begin
		int limit;
		limit = 200 * (NROWS + 1);
		for (int i = 0; i < NROWS; i++) begin
			limit = limit + 20 * int'(ROWS[i].len);
		end
		repeat (limit) @(posedge usr_clk);
		$display("timeout: no finish after %0d cycles, a handshake is hung", limit);
		$display("SIMULATION FAILED");
		$fatal(1);
	end

	initial begin
		logic [31:0] data;
		logic [1:0]  resp;
		usr_clk    = 1'b0;
		rst_i      = 1'b1;
		awaddr     = '0;
		awvalid    = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		wvalid     = 1'b0;
		bready     = 1'b0;
		araddr     = '0;
		arvalid    = 1'b0;
		rready     = 1'b0;
		h2c_tdata  = '0;
		h2c_tlast  = 1'b0;
		h2c_tvalid = 1'b0;
		c2h_tready = 1'b0;
		irq_ack    = '0;
		lfsr       = 16'd74;
		exp_beats  = '0;
		exp_errs   = '0;
		repeat (5) @(posedge usr_clk);
		rst_i <= 1'b0;
		@(negedge usr_clk);
		check_value("awready", awready, 0);
		check_value("wready", wready, 0);
		check_value("bvalid", bvalid, 0);
		check_value("arready", arready, 0);
		check_value("rvalid", rvalid, 0);
		check_value("c2h_tvalid", c2h_tvalid, 0);
		check_value("h2c_tready", h2c_tready, 0);
		check_value("usr_irq_req", irq_req, 0);
		lite_read(32'(REG_ID), data, resp);
		check_value("REG_ID", data, APP_ID);
		check_value("rresp", resp, RESP_OKAY);
		lite_read(32'h0000_0020, data, resp);
		check_value("unmapped rdata", data, 0);
		check_value("unmapped rresp", resp, RESP_SLVERR);
		lite_read(32'(REG_CTRL), data, resp);
		check_value("REG_CTRL", data, 32'(MODE_OFF));
		lite_write(32'(REG_C2H_LEN), 32'h0000_1234);
		lite_read(32'(REG_C2H_LEN), data, resp);
		check_value("REG_C2H_LEN", data, 32'h0000_1234);
		for (int i = 0; i < NROWS; i++) begin
			if (ROWS[i].mode == MODE_C2H && ROWS[i].len != 0) begin
				gen_frame_row(ROWS[i]);
			end else if (ROWS[i].mode == MODE_H2C) begin
				checker_frame_row(ROWS[i]);
			end else if (ROWS[i].mode == MODE_LOOP) begin
				loopback_row(ROWS[i], i);
			end else begin
				ignored_start_row(ROWS[i]);
			end
		end
		// error count clears on write while the beat count stays
		lite_write(32'(REG_H2C_ERR), 32'd0);
		lite_read(32'(REG_H2C_ERR), data, resp);
		check_value("REG_H2C_ERR", data, 0);
		lite_read(32'(REG_H2C_BEATS), data, resp);
		check_value("REG_H2C_BEATS", data, exp_beats);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sgdma_app.sv */
// top level of the DMA user test application, joins register block, checker and generator by mode
`timescale 1ns/1ns
`default_nettype none

module sgdma_app import app_stream_pkg::*; #(
	parameter int DATA_W = DATA_W_DEF,
	parameter int LEN_W  = LEN_W_DEF
) (
	input  wire               usr_clk,
	input  wire               rst_i,
	input  wire  [31:0]       awaddr_i,
	input  wire               awvalid_i,
	output logic              awready_o,
	input  wire  [31:0]       wdata_i,
	input  wire  [3:0]        wstrb_i,
	input  wire               wvalid_i,
	output logic              wready_o,
	output logic              bvalid_o,
	output logic [1:0]        bresp_o,
	input  wire               bready_i,
	input  wire  [31:0]       araddr_i,
	input  wire               arvalid_i,
	output logic              arready_o,
	output logic [31:0]       rdata_o,
	output logic [1:0]        rresp_o,
	output logic              rvalid_o,
	input  wire               rready_i,
	input  wire  [DATA_W-1:0] h2c_tdata_i,
	input  wire               h2c_tlast_i,
	input  wire               h2c_tvalid_i,
	output logic              h2c_tready_o,
	output logic [DATA_W-1:0] c2h_tdata_o,
	output logic              c2h_tlast_o,
	output logic              c2h_tvalid_o,
	input  wire               c2h_tready_i,
	output logic [1:0]        usr_irq_req_o,
	input  wire  [1:0]        usr_irq_ack_i
);

	app_mode_e         mode;
	logic [LEN_W-1:0]  c2h_len;
	logic              c2h_start;
	logic              err_clr;
	logic              beats_clr;
	logic [31:0]       err_cnt;
	logic [31:0]       beat_cnt;
	logic              chk_tvalid;
	logic              chk_tready;
	logic              chk_irq;
	logic              gen_start;
	logic              gen_tready;
	logic [DATA_W-1:0] gen_tdata;
	logic              gen_tlast;
	logic              gen_tvalid;
	logic              gen_irq;

	app_reg_file #(
		.LEN_W(LEN_W)
	) i_app_reg_file (
		.usr_clk(usr_clk),
		.rst_i(rst_i),
		.awaddr_i(awaddr_i),
		.awvalid_i(awvalid_i),
		.awready_o(awready_o),
		.wdata_i(wdata_i),
		.wstrb_i(wstrb_i),
		.wvalid_i(wvalid_i),
		.wready_o(wready_o),
		.bvalid_o(bvalid_o),
		.bresp_o(bresp_o),
		.bready_i(bready_i),
		.araddr_i(araddr_i),
		.arvalid_i(arvalid_i),
		.arready_o(arready_o),
		.rdata_o(rdata_o),
		.rresp_o(rresp_o),
		.rvalid_o(rvalid_o),
		.rready_i(rready_i),
		.mode_o(mode),
		.c2h_len_o(c2h_len),
		.c2h_start_o(c2h_start),
		.err_clr_o(err_clr),
		.beats_clr_o(beats_clr),
		.err_cnt_i(err_cnt),
		.beat_cnt_i(beat_cnt)
	);

	// engines only see traffic in their own mode
	assign chk_tvalid = h2c_tvalid_i && (mode == MODE_H2C);
	assign gen_start  = c2h_start && (mode == MODE_C2H);
	assign gen_tready = c2h_tready_i && (mode == MODE_C2H);

	h2c_checker #(
		.DATA_W(DATA_W)
	) i_h2c_checker (
		.usr_clk(usr_clk),
		.rst_i(rst_i),
		.tdata_i(h2c_tdata_i),
		.tlast_i(h2c_tlast_i),
		.tvalid_i(chk_tvalid),
		.tready_o(chk_tready),
		.err_clr_i(err_clr),
		.beats_clr_i(beats_clr),
		.err_cnt_o(err_cnt),
		.beat_cnt_o(beat_cnt),
		.irq_req_o(chk_irq),
		.irq_ack_i(usr_irq_ack_i[0])
	);

	c2h_generator #(
		.DATA_W(DATA_W),
		.LEN_W(LEN_W)
	) i_c2h_generator (
		.usr_clk(usr_clk),
		.rst_i(rst_i),
		.start_i(gen_start),
		.len_i(c2h_len),
		.tdata_o(gen_tdata),
		.tlast_o(gen_tlast),
		.tvalid_o(gen_tvalid),
		.tready_i(gen_tready),
		.irq_req_o(gen_irq),
		.irq_ack_i(usr_irq_ack_i[1])
	);

	// bit0 host-to-card, bit1 card-to-host
	assign usr_irq_req_o = {gen_irq, chk_irq};

	// stream routing by mode
	always_comb begin
		h2c_tready_o = 1'b0;
		c2h_tdata_o  = '0;
		c2h_tlast_o  = 1'b0;
		c2h_tvalid_o = 1'b0;
		case (mode)
			MODE_H2C: h2c_tready_o = chk_tready;
			MODE_C2H: begin
				c2h_tdata_o  = gen_tdata;
				c2h_tlast_o  = gen_tlast;
				c2h_tvalid_o = gen_tvalid;
			end
			MODE_LOOP: begin
				// straight wire path, no buffering
				h2c_tready_o = c2h_tready_i;
				c2h_tdata_o  = h2c_tdata_i;
				c2h_tlast_o  = h2c_tlast_i;
				c2h_tvalid_o = h2c_tvalid_i;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* c2h_generator.sv */
// card-to-host frame generator, sends one counting-pattern frame per start and raises an interrupt
`timescale 1ns/1ns
`default_nettype none

module c2h_generator import app_stream_pkg::*; #(
	parameter int DATA_W = DATA_W_DEF,
	parameter int LEN_W  = LEN_W_DEF
) (
	input  wire               usr_clk,
	input  wire               rst_i,
	input  wire               start_i,
	input  wire  [LEN_W-1:0]  len_i,
	output logic [DATA_W-1:0] tdata_o,
	output logic              tlast_o,
	output logic              tvalid_o,
	input  wire               tready_i,
	output logic              irq_req_o,
	input  wire               irq_ack_i
);

	localparam int HALF_W = DATA_W / 2;

	gen_state_e        state;
	logic [LEN_W-1:0]  len_q;
	logic [LEN_W-1:0]  idx;
	logic [HALF_W-1:0] idx_half;
	logic              last_beat;
	logic              beat_done;

	// index resized to one half of the data word
	assign idx_half  = HALF_W'(idx);
	assign tdata_o   = {idx_half, idx_half};
	assign tvalid_o  = (state == GEN_SEND);
	assign last_beat = (idx == len_q - 1'b1);
	assign tlast_o   = tvalid_o && last_beat;
	assign beat_done = tvalid_o && tready_i;
	assign irq_req_o = (state == GEN_IRQ);

	// frame FSM
	always_ff @(posedge usr_clk) begin
		if (rst_i) begin
			state <= GEN_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				GEN_IDLE: begin
					// zero length start is dropped
					if (start_i && len_i != '0) begin
						state <= GEN_SEND;
						idx   <= '0;
					end
				end
				GEN_SEND: begin
					// index only moves on a handshake, so data holds
					if (beat_done) begin
						if (last_beat) begin
							state <= GEN_IRQ;
						end else begin
							idx <= idx + 1'b1;
						end
					end
				end
				GEN_IRQ: begin
					if (irq_ack_i) begin
						state <= GEN_IDLE;
					end
				end
				default: state <= GEN_IDLE;
			endcase
		end
	end

	// frame length latched at start, later writes don't disturb a frame
	always_ff @(posedge usr_clk) begin
		if (state == GEN_IDLE && start_i) begin
			len_q <= len_i;
		end
	end

endmodule

`default_nettype wire

/* h2c_checker.sv */
// host-to-card stream checker, compares beats to the counting pattern and counts beats and errors
`timescale 1ns/1ns
`default_nettype none

module h2c_checker import app_stream_pkg::*; #(
	parameter int DATA_W = DATA_W_DEF
) (
	input  wire               usr_clk,
	input  wire               rst_i,
	input  wire  [DATA_W-1:0] tdata_i,
	input  wire               tlast_i,
	input  wire               tvalid_i,
	output logic              tready_o,
	input  wire               err_clr_i,
	input  wire               beats_clr_i,
	output logic [31:0]       err_cnt_o,
	output logic [31:0]       beat_cnt_o,
	output logic              irq_req_o,
	input  wire               irq_ack_i
);

	localparam int HALF_W = DATA_W / 2;

	chk_state_e        state;
	logic [HALF_W-1:0] k;
	logic              accept;
	logic              mismatch;

	// no beats taken while the interrupt is pending
	assign tready_o  = (state == CHK_RECV);
	assign irq_req_o = (state == CHK_IRQ);
	assign accept    = tvalid_i && tready_o;
	// expected word has k in both halves
	assign mismatch  = (tdata_i != {k, k});

	// frame FSM and beat index
	always_ff @(posedge usr_clk) begin
		if (rst_i) begin
			state <= CHK_RECV;
			k     <= '0;
		end else begin
			case (state)
				CHK_RECV: begin
					if (accept) begin
						if (tlast_i) begin
							// next frame starts again at 0
							state <= CHK_IRQ;
							k     <= '0;
						end else begin
							k <= k + 1'b1;
						end
					end
				end
				CHK_IRQ: begin
					// hold req until host acks
					if (irq_ack_i) begin
						state <= CHK_RECV;
					end
				end
				default: state <= CHK_RECV;
			endcase
		end
	end

	// counters, clear wins over count
	always_ff @(posedge usr_clk) begin
		if (rst_i) begin
			err_cnt_o  <= '0;
			beat_cnt_o <= '0;
		end else begin
			if (beats_clr_i) begin
				beat_cnt_o <= '0;
			end else if (accept && beat_cnt_o != '1) begin
				beat_cnt_o <= beat_cnt_o + 1'b1;
			end
			if (err_clr_i) begin
				err_cnt_o <= '0;
			end else if (accept && mismatch && err_cnt_o != '1) begin
				// saturate, never wrap to 0
				err_cnt_o <= err_cnt_o + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* app_reg_file.sv */
// AXI-Lite slave with mode, frame length and start control, plus read-back of the checker counters
`timescale 1ns/1ns
`default_nettype none

module app_reg_file import app_stream_pkg::*, app_reg_pkg::*; #(
	parameter int LEN_W = LEN_W_DEF
) (
	input  wire              usr_clk,
	input  wire              rst_i,
	input  wire  [31:0]      awaddr_i,
	input  wire              awvalid_i,
	output logic             awready_o,
	input  wire  [31:0]      wdata_i,
	input  wire  [3:0]       wstrb_i,
	input  wire              wvalid_i,
	output logic             wready_o,
	output logic             bvalid_o,
	output logic [1:0]       bresp_o,
	input  wire              bready_i,
	input  wire  [31:0]      araddr_i,
	input  wire              arvalid_i,
	output logic             arready_o,
	output logic [31:0]      rdata_o,
	output logic [1:0]       rresp_o,
	output logic             rvalid_o,
	input  wire              rready_i,
	output app_mode_e        mode_o,
	output logic [LEN_W-1:0] c2h_len_o,
	output logic             c2h_start_o,
	output logic             err_clr_o,
	output logic             beats_clr_o,
	input  wire  [31:0]      err_cnt_i,
	input  wire  [31:0]      beat_cnt_i
);

	logic        aw_take;
	logic        wr_fire;
	logic        rd_fire;
	logic        wr_map;
	logic        rd_map;
	reg_addr_e   wr_addr;
	reg_addr_e   rd_addr;
	logic [31:0] wmask;
	logic [31:0] rd_mux;

	// true when the offset names a register
	function automatic logic is_mapped(input logic [31:0] addr);
		logic hit;
		hit = 1'b0;
		if (addr[31:8] == '0) begin
			case (reg_addr_e'(addr[7:0]))
				REG_CTRL, REG_C2H_LEN, REG_H2C_ERR, REG_H2C_BEATS, REG_ID: hit = 1'b1;
				default: hit = 1'b0;
			endcase
		end
		return hit;
	endfunction

	assign wr_addr = reg_addr_e'(awaddr_i[7:0]);
	assign rd_addr = reg_addr_e'(araddr_i[7:0]);
	assign wr_map  = is_mapped(awaddr_i);
	assign rd_map  = is_mapped(araddr_i);

	// address and data taken together, one transfer at a time
	assign aw_take = awvalid_i && wvalid_i && !bvalid_o && !awready_o;
	assign wr_fire = awready_o && awvalid_i && wvalid_i;
	assign rd_fire = arready_o && arvalid_i;

	// byte lanes to bit mask
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			wmask[8*i +: 8] = {8{wstrb_i[i]}};
		end
	end

	// write channel and control registers
	always_ff @(posedge usr_clk) begin
		if (rst_i) begin
			awready_o   <= 1'b0;
			wready_o    <= 1'b0;
			bvalid_o    <= 1'b0;
			bresp_o     <= RESP_OKAY;
			mode_o      <= MODE_OFF;
			c2h_len_o   <= '0;
			c2h_start_o <= 1'b0;
			err_clr_o   <= 1'b0;
			beats_clr_o <= 1'b0;
		end else begin
			awready_o   <= aw_take;
			wready_o    <= aw_take;
			// strobes last one cycle
			c2h_start_o <= 1'b0;
			err_clr_o   <= 1'b0;
			beats_clr_o <= 1'b0;
			if (wr_fire) begin
				bvalid_o <= 1'b1;
				bresp_o  <= wr_map ? RESP_OKAY : RESP_SLVERR;
				if (wr_map) begin
					case (wr_addr)
						REG_CTRL: begin
							// mode and start live in byte 0
							if (wstrb_i[0]) begin
								mode_o      <= app_mode_e'(wdata_i[1:0]);
								c2h_start_o <= wdata_i[CTRL_START_BIT];
							end
						end
						REG_C2H_LEN: begin
							c2h_len_o <= (c2h_len_o & ~wmask[LEN_W-1:0]) |
								(wdata_i[LEN_W-1:0] & wmask[LEN_W-1:0]);
						end
						// any write clears, data ignored
						REG_H2C_ERR: err_clr_o <= 1'b1;
						REG_H2C_BEATS: beats_clr_o <= 1'b1;
						default: ;
					endcase
				end
			end else if (bready_i) begin
				bvalid_o <= 1'b0;
			end
		end
	end

	// read data select, start bit always reads 0
	always_comb begin
		rd_mux = '0;
		if (rd_map) begin
			case (rd_addr)
				REG_CTRL: rd_mux = {30'd0, mode_o};
				REG_C2H_LEN: rd_mux = 32'(c2h_len_o);
				REG_H2C_ERR: rd_mux = err_cnt_i;
				REG_H2C_BEATS: rd_mux = beat_cnt_i;
				REG_ID: rd_mux = APP_ID;
				default: rd_mux = '0;
			endcase
		end
	end

	// read address and response handshake
	always_ff @(posedge usr_clk) begin
		if (rst_i) begin
			arready_o <= 1'b0;
			rvalid_o  <= 1'b0;
			rresp_o   <= RESP_OKAY;
		end else begin
			arready_o <= arvalid_i && !rvalid_o && !arready_o;
			if (rd_fire) begin
				rvalid_o <= 1'b1;
				rresp_o  <= rd_map ? RESP_OKAY : RESP_SLVERR;
			end else if (rready_i) begin
				rvalid_o <= 1'b0;
			end
		end
	end

	// read payload, captured with the address
	always_ff @(posedge usr_clk) begin
		if (rd_fire) begin
			rdata_o <= rd_mux;
		end
	end

endmodule

`default_nettype wire

/* app_reg_pkg.sv */
// AXI-Lite register map, response codes and ID value, imported by the register block and testbench
`default_nettype none

package app_reg_pkg;

	// byte offsets, low address byte only
	// upper address bits must be zero for a hit
	typedef enum logic [7:0] {
		REG_CTRL      = 8'h00,
		REG_C2H_LEN   = 8'h04,
		REG_H2C_ERR   = 8'h08,
		REG_H2C_BEATS = 8'h0C,
		REG_ID        = 8'h10
	} reg_addr_e;

	// REG_CTRL fields
	localparam int CTRL_START_BIT = 4;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	// fixed value of REG_ID
	localparam logic [31:0] APP_ID = 32'h5D4A_0001;

endpackage

`default_nettype wire

/* app_stream_pkg.sv */
// stream-side defaults and state/mode types, imported by the engines, the top level and the testbench
`default_nettype none

package app_stream_pkg;

	// default stream data width, two equal pattern halves
	localparam int DATA_W_DEF = 64;
	// default width of frame length and beat index
	localparam int LEN_W_DEF = 16;

	// stream routing mode, written through REG_CTRL[1:0]
	typedef enum logic [1:0] {
		MODE_OFF  = 2'd0,
		MODE_H2C  = 2'd1,
		MODE_C2H  = 2'd2,
		MODE_LOOP = 2'd3
	} app_mode_e;

	// host-to-card checker FSM
	typedef enum logic {
		CHK_RECV = 1'b0,
		CHK_IRQ  = 1'b1
	} chk_state_e;

	// card-to-host generator FSM
	typedef enum logic [1:0] {
		GEN_IDLE = 2'd0,
		GEN_SEND = 2'd1,
		GEN_IRQ  = 2'd2
	} gen_state_e;

endpackage

`default_nettype wire
